// ==== design/coreSlice_macros.svh ====
`ifndef CORESLICE_MACROS_SVH
`define CORESLICE_MACROS_SVH

// Instruction queue entries
// The sender starts with exactly this many credits
`define CORE_QUEUE_DEPTH 4

// Integer data width
`define CORE_XLEN 32

// Architectural register count
`define CORE_NREGS 32

`endif

// ==== design/coreSlice_pkg.sv ====
`default_nettype none

`include "coreSlice_macros.svh"

package coreSlice_pkg;

	// Major opcodes handled by the slice
	localparam logic [6:0] opcodeOp    = 7'b0110011;
	localparam logic [6:0] opcodeOpImm = 7'b0010011;
	localparam logic [6:0] opcodeLui   = 7'b0110111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeFields;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iTypeFields;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uTypeFields;

	// Same fetched word seen through each format
	typedef union packed {
		logic [31:0] raw;
		rTypeFields  r;
		iTypeFields  i;
		uTypeFields  u;
	} instrWord;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOp;

	typedef struct packed {
		logic [4:0]            rs1;
		logic [4:0]            rs2;
		logic [4:0]            rd;
		aluOp                  aluOp;
		logic                  useImm;
		logic [`CORE_XLEN-1:0] imm;
		logic                  writeEn;
		logic                  illegal;
	} decodedInstr;

	typedef struct packed {
		logic                  valid;
		logic [4:0]            rd;
		logic                  writeEn;
		aluOp                  aluOp;
		logic [`CORE_XLEN-1:0] opA;
		logic [`CORE_XLEN-1:0] opB;
	} issuedInstr;

	// Writeback bus, also the register file write port
	typedef struct packed {
		logic                  valid;
		logic [4:0]            rd;
		logic [`CORE_XLEN-1:0] data;
	} wbBus;

endpackage

`default_nettype wire

// ==== design/instrQueue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module instrQueue (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    instrValid,
	input  logic [31:0]             instr,
	input  logic                    pop,
	output logic                    headValid,
	output coreSlice_pkg::instrWord head,
	output logic                    creditReturn
);

	localparam int ptrWidth = (`CORE_QUEUE_DEPTH > 1) ? $clog2(`CORE_QUEUE_DEPTH) : 1;
	localparam int cntWidth = $clog2(`CORE_QUEUE_DEPTH + 1);

	logic [31:0]         mem [`CORE_QUEUE_DEPTH];
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] wrPtr;
	logic [cntWidth-1:0] count;
	logic                full;
	logic                doPush;
	logic                doPop;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		// Wrap explicitly so any depth works
		if (ptr == ptrWidth'(`CORE_QUEUE_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign full      = (count == cntWidth'(`CORE_QUEUE_DEPTH));
	assign headValid = (count != '0);
	assign doPop     = pop && headValid;
	assign doPush    = instrValid && (!full || doPop);

	// One credit back for every entry that leaves
	assign creditReturn = doPop;

	assign head.raw = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= instr;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			// Simultaneous push and pop leave the count alone
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
	input  coreSlice_pkg::instrWord    head,
	output coreSlice_pkg::decodedInstr dec
);

	import coreSlice_pkg::*;

	logic [31:0] iImm;
	logic [31:0] shImm;
	logic [31:0] uImm;

	assign iImm  = {{20{head.i.imm[11]}}, head.i.imm};
	// Shift amount sits where rs2 would be
	assign shImm = {27'b0, head.r.rs2};
	assign uImm  = {head.u.imm, 12'b0};

	always_comb
	begin
		dec        = '0;
		dec.rd     = head.r.rd;
		dec.rs1    = head.r.rs1;
		dec.aluOp  = aluAdd;
		case (head.r.opcode)
			opcodeOp:
			begin
				dec.rs2 = head.r.rs2;
				if (head.r.funct7 == 7'b0000000)
				begin
					case (head.r.funct3)
						3'b000:  dec.aluOp = aluAdd;
						3'b001:  dec.aluOp = aluSll;
						3'b010:  dec.aluOp = aluSlt;
						3'b100:  dec.aluOp = aluXor;
						3'b101:  dec.aluOp = aluSrl;
						3'b110:  dec.aluOp = aluOr;
						3'b111:  dec.aluOp = aluAnd;
						default: dec.illegal = 1'b1;
					endcase
				end
				else if (head.r.funct7 == 7'b0100000 && head.r.funct3 == 3'b000)
					dec.aluOp = aluSub;
				else
					dec.illegal = 1'b1;
			end
			opcodeOpImm:
			begin
				dec.useImm = 1'b1;
				dec.imm    = iImm;
				case (head.i.funct3)
					3'b000:  dec.aluOp = aluAdd;
					3'b100:  dec.aluOp = aluXor;
					3'b110:  dec.aluOp = aluOr;
					3'b111:  dec.aluOp = aluAnd;
					3'b001:
					begin
						dec.aluOp   = aluSll;
						dec.imm     = shImm;
						dec.illegal = (head.r.funct7 != 7'b0000000);
					end
					// SLTI, SLTIU and right shifts by immediate are not supported
					default: dec.illegal = 1'b1;
				endcase
			end
			opcodeLui:
			begin
				dec.rs1    = 5'd0;
				dec.useImm = 1'b1;
				dec.imm    = uImm;
				dec.aluOp  = aluPassB;
			end
			default:   dec.illegal = 1'b1;
		endcase

		// Illegal words read and write nothing
		if (dec.illegal)
		begin
			dec.rs1 = 5'd0;
			dec.rs2 = 5'd0;
			dec.rd  = 5'd0;
		end
		dec.writeEn = !dec.illegal && (dec.rd != 5'd0);
	end

endmodule

`default_nettype wire

// ==== design/scoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module scoreboard (
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       headValid,
	input  coreSlice_pkg::decodedInstr dec,
	input  coreSlice_pkg::wbBus        wb,
	output logic                       issueFire
);

	logic [`CORE_NREGS-1:0] pending;
	// Destination of the instruction now in the issue register
	logic [4:0]             lastRd;
	logic                   lastWr;
	logic                   wbFrees;
	logic                   busy1;
	logic                   busy2;

	// A writeback frees its rd unless a younger write to it is in flight
	assign wbFrees = wb.valid && !(lastWr && lastRd == wb.rd);

	// Register file writes through, so a freeing writeback counts as ready
	assign busy1 = (dec.rs1 != 5'd0) && pending[dec.rs1] &&
		!(wbFrees && wb.rd == dec.rs1);
	assign busy2 = (dec.rs2 != 5'd0) && pending[dec.rs2] &&
		!(wbFrees && wb.rd == dec.rs2);

	assign issueFire = headValid && (dec.illegal || (!busy1 && !busy2));

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pending <= '0;
			lastRd  <= 5'd0;
			lastWr  <= 1'b0;
		end
		else
		begin
			if (wbFrees)
				pending[wb.rd] <= 1'b0;
			// Set after clear so a new producer of the same rd wins
			if (issueFire && dec.writeEn)
				pending[dec.rd] <= 1'b1;
			lastRd <= dec.rd;
			lastWr <= issueFire && dec.writeEn;
		end
	end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module regFile (
	input  logic                clk,
	input  logic                nrst,
	input  logic [4:0]          rs1,
	input  logic [4:0]          rs2,
	input  coreSlice_pkg::wbBus wb,
	output logic [31:0]         rdata1,
	output logic [31:0]         rdata2
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

	// Write-through of the value being written this cycle
	assign rdata1 = (rs1 == 5'd0) ? '0 :
		(wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 :
		(wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.rd != 5'd0)
			regs[wb.rd] <= wb.data;
	end

endmodule

`default_nettype wire

// ==== design/issueStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module issueStage (
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       issueFire,
	input  coreSlice_pkg::decodedInstr dec,
	input  logic [31:0]                rdata1,
	input  logic [31:0]                rdata2,
	output coreSlice_pkg::issuedInstr  iss
);

	import coreSlice_pkg::*;

	issuedInstr nextIss;
	logic       loadBubble;

	// Stalled or illegal heads become a bubble
	assign loadBubble = !issueFire || dec.illegal;

	always_comb
	begin
		if (loadBubble)
		begin
			nextIss         = '0;
			nextIss.aluOp   = aluAdd;
		end
		else
		begin
			nextIss.valid   = 1'b1;
			nextIss.rd      = dec.rd;
			nextIss.writeEn = dec.writeEn;
			nextIss.aluOp   = dec.aluOp;
			nextIss.opA     = rdata1;
			// Operand B from register or immediate
			nextIss.opB     = dec.useImm ? dec.imm : rdata2;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			iss <= '0;
		else
			iss <= nextIss;
	end

endmodule

`default_nettype wire

// ==== design/aluExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module aluExecute (
	input  logic                      clk,
	input  logic                      nrst,
	input  coreSlice_pkg::issuedInstr iss,
	output coreSlice_pkg::wbBus       wb
);

	import coreSlice_pkg::*;

	logic [`CORE_XLEN-1:0] result;
	logic [4:0]            shamt;

	// Shifts only look at the low five bits
	assign shamt = iss.opB[4:0];

	always_comb
	begin
		case (iss.aluOp)
			aluAdd:   result = iss.opA + iss.opB;
			aluSub:   result = iss.opA - iss.opB;
			aluAnd:   result = iss.opA & iss.opB;
			aluOr:    result = iss.opA | iss.opB;
			aluXor:   result = iss.opA ^ iss.opB;
			aluSlt:
			begin
				// Signed compare
				if ($signed(iss.opA) < $signed(iss.opB))
					result = `CORE_XLEN'(1);
				else
					result = '0;
			end
			aluSll:   result = iss.opA << shamt;
			aluSrl:   result = iss.opA >> shamt;
			aluPassB: result = iss.opB;
			default:  result = '0;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wb <= '0;
		else
		begin
			wb.valid <= iss.valid && iss.writeEn;
			wb.rd    <= iss.rd;
			wb.data  <= result;
		end
	end

endmodule

`default_nettype wire

// ==== design/coreSlice.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreSlice (
	input  logic                clk,
	input  logic                nrst,
	input  logic                instrValid,
	input  logic [31:0]         instr,
	output logic                creditReturn,
	output coreSlice_pkg::wbBus wb
);

	import coreSlice_pkg::*;

	logic        headValid;
	instrWord    head;
	decodedInstr dec;
	logic        issueFire;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	issuedInstr  iss;

	instrQueue queue (
		.clk          (clk),
		.nrst         (nrst),
		.instrValid   (instrValid),
		.instr        (instr),
		.pop          (issueFire),
		.headValid    (headValid),
		.head         (head),
		.creditReturn (creditReturn)
	);

	instrDecoder decoder (
		.head (head),
		.dec  (dec)
	);

	scoreboard board (
		.clk       (clk),
		.nrst      (nrst),
		.headValid (headValid),
		.dec       (dec),
		.wb        (wb),
		.issueFire (issueFire)
	);

	// Read ports follow the head being issued
	regFile regs (
		.clk    (clk),
		.nrst   (nrst),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.wb     (wb),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	issueStage issue (
		.clk       (clk),
		.nrst      (nrst),
		.issueFire (issueFire),
		.dec       (dec),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.iss       (iss)
	);

	aluExecute execute (
		.clk  (clk),
		.nrst (nrst),
		.iss  (iss),
		.wb   (wb)
	);

endmodule

`default_nettype wire

// ==== verification/wbChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module wbChecker (
	input  logic                clk,
	input  logic                nrst,
	input  logic                instrValid,
	input  logic                creditReturn,
	input  coreSlice_pkg::wbBus wb,
	input  logic                drained,
	output logic                reportDone,
	output logic                checkFailed
);

	localparam int maxEntries = 64;

	logic [31:0] trace [4*maxEntries];
	int          numEntries;
	// Next entry that expects a writeback
	int          nextIdx;
	int          sentSeen;
	int          returnedSeen;
	int          testErrors;
	int          testsPassed;
	int          testsFailed;
	int          otherErrors;

	function automatic int findWriter(input int from);
		int idx;
		idx = from;
		while (idx < numEntries && trace[4*idx+2] == 32'h0)
			idx++;
		return idx;
	endfunction

	function automatic logic lastOfTest(input int idx);
		int nxt;
		nxt = findWriter(idx + 1);
		return (nxt >= numEntries) || (trace[4*nxt] != trace[4*idx]);
	endfunction

	initial
	begin
		$readmemh("verification/coreSlice_trace.txt", trace);
		numEntries = 0;
		while (numEntries < maxEntries && !$isunknown(trace[4*numEntries]))
			numEntries++;
		nextIdx      = findWriter(0);
		sentSeen     = 0;
		returnedSeen = 0;
		testErrors   = 0;
		testsPassed  = 0;
		testsFailed  = 0;
		otherErrors  = 0;
		reportDone   = 1'b0;
		checkFailed  = 1'b0;
	end

	task automatic checkWriteback();
		int          testNum;
		logic [4:0]  expRd;
		logic [31:0] expData;
		if (sentSeen == 0 || nextIdx >= numEntries)
		begin
			$display("Writeback to x%0d arrived when none was expected", wb.rd);
			otherErrors++;
			return;
		end
		testNum = trace[4*nextIdx];
		expRd   = trace[4*nextIdx+2][4:0];
		expData = trace[4*nextIdx+3];
		if (wb.rd !== expRd)
		begin
			$display("ERROR: test %0d entry %0d wb.rd expected %h got %h",
				testNum, nextIdx, expRd, wb.rd);
			testErrors++;
		end
		if (wb.data !== expData)
		begin
			$display("ERROR: test %0d entry %0d wb.data expected %h got %h",
				testNum, nextIdx, expData, wb.data);
			testErrors++;
		end
		if (lastOfTest(nextIdx))
		begin
			if (testErrors == 0)
			begin
				$display("Test %0d: PASS", testNum);
				testsPassed++;
			end
			else
			begin
				$display("Test %0d: FAIL with %0d mismatches", testNum, testErrors);
				testsFailed++;
			end
			testErrors = 0;
		end
		nextIdx = findWriter(nextIdx + 1);
	endtask

	task automatic finalReport();
		if (numEntries == 0)
		begin
			$display("The trace file holds no entries");
			otherErrors++;
		end
		if (nextIdx < numEntries)
		begin
			$display("Writeback for entry %0d and later never arrived", nextIdx);
			otherErrors++;
		end
		if (returnedSeen != sentSeen || sentSeen != numEntries)
		begin
			$display("Credit count is off: %0d sent, %0d returned, %0d in the trace",
				sentSeen, returnedSeen, numEntries);
			otherErrors++;
		end
		$display("Summary: passing tests %0d, failing tests %0d, other errors %0d",
			testsPassed, testsFailed, otherErrors);
		checkFailed = (testsFailed != 0) || (otherErrors != 0);
		reportDone  = 1'b1;
	endtask

	// Everything sampled mid-cycle where outputs are settled
	always @(negedge clk)
	begin
		if (nrst && !reportDone)
		begin
			if (creditReturn && returnedSeen >= sentSeen)
			begin
				$display("Credit returned with no instruction in the queue");
				otherErrors++;
			end
			if (instrValid && sentSeen - returnedSeen >= `CORE_QUEUE_DEPTH)
			begin
				$display("Sender drove an instruction with no credit left");
				otherErrors++;
			end
			if (creditReturn)
				returnedSeen++;
			if (instrValid)
				sentSeen++;
			if (wb.valid)
				checkWriteback();
			if (drained)
				finalReport();
		end
	end

endmodule

`default_nettype wire

// ==== verification/coreSlice_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "coreSlice_macros.svh"

module coreSlice_tb;

	import coreSlice_pkg::*;

	localparam int maxEntries    = 64;
	localparam int creditTimeout = 200;
	localparam int drainTimeout  = 200;
	localparam int reportTimeout = 20;

	logic        clk;
	logic        nrst;
	logic        instrValid;
	logic [31:0] instr;
	logic        creditReturn;
	wbBus        wb;
	logic        drained;
	logic        reportDone;
	logic        checkFailed;

	// Four words per entry: test, instruction, rd, result
	logic [31:0] trace [4*maxEntries];
	int          numEntries;
	int          sentCount;
	int          returnedCredits;
	integer      seed;
	logic        timedOut;

	coreSlice uut (
		.clk          (clk),
		.nrst         (nrst),
		.instrValid   (instrValid),
		.instr        (instr),
		.creditReturn (creditReturn),
		.wb           (wb)
	);

	wbChecker wbCheck (
		.clk          (clk),
		.nrst         (nrst),
		.instrValid   (instrValid),
		.creditReturn (creditReturn),
		.wb           (wb),
		.drained      (drained),
		.reportDone   (reportDone),
		.checkFailed  (checkFailed)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Returned credits, sampled mid-cycle
	always @(negedge clk)
	begin
		if (!nrst)
			returnedCredits <= 0;
		else if (creditReturn)
			returnedCredits <= returnedCredits + 1;
	end

	function automatic int creditsLeft();
		return `CORE_QUEUE_DEPTH - sentCount + returnedCredits;
	endfunction

	task automatic idleCycle();
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic sendWord(input logic [31:0] word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= word;
		sentCount  = sentCount + 1;
	endtask

	task automatic driveTrace();
		int gap;
		int waited;
		for (int i = 0; i < numEntries; i++)
		begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap)
				idleCycle();
			waited = 0;
			while (creditsLeft() == 0 && waited < creditTimeout)
			begin
				idleCycle();
				waited++;
			end
			if (creditsLeft() == 0)
			begin
				$display("Timeout: no credit came back for entry %0d within %0d cycles",
					i, waited);
				timedOut = 1'b1;
				break;
			end
			sendWord(trace[4*i+1]);
		end
		idleCycle();
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (returnedCredits != sentCount && waited < drainTimeout)
		begin
			idleCycle();
			waited++;
		end
		if (returnedCredits != sentCount)
		begin
			$display("Timeout: only %0d of %0d instructions left the queue",
				returnedCredits, sentCount);
			timedOut = 1'b1;
		end
		else
		begin
			// Last issue writes back two cycles after its credit
			repeat (4)
				idleCycle();
		end
	endtask

	task automatic awaitReport();
		int waited;
		waited = 0;
		drained = 1'b1;
		while (!reportDone && waited < reportTimeout)
		begin
			idleCycle();
			waited++;
		end
		if (!reportDone)
		begin
			$display("Timeout: the checker never produced its summary");
			timedOut = 1'b1;
		end
	endtask

	initial
	begin
		seed       = 32'h9234c64f;
		nrst       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		drained    = 1'b0;
		sentCount  = 0;
		timedOut   = 1'b0;
		$readmemh("verification/coreSlice_trace.txt", trace);
		numEntries = 0;
		while (numEntries < maxEntries && !$isunknown(trace[4*numEntries]))
			numEntries++;
		repeat (5)
			@(posedge clk);
		nrst <= 1'b1;
		// Quiet cycles so idle outputs after reset get watched
		repeat (3)
			idleCycle();
		driveTrace();
		if (!timedOut)
			drainPipe();
		if (!timedOut)
			awaitReport();
		if (!timedOut && !checkFailed)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/coreSlice_trace.txt ====
// Columns, all hex: test number, instruction word, expected rd, expected result
// An rd of 0 means no writeback is expected for that entry
1 003100B3 01 00000000
1 0062E233 04 00000000
2 06400093 01 00000064
2 FF900113 02 FFFFFFF9
2 0F000193 03 000000F0
2 00308233 04 00000154
2 402082B3 05 0000006B
2 0030F333 06 00000060
2 0030E3B3 07 000000F4
2 0030C433 08 00000094
2 001124B3 09 00000001
2 0020A533 0A 00000000
2 003095B3 0B 00640000
2 00115633 0C 0FFFFFFF
2 00509693 0D 00000C80
2 ABCDE737 0E ABCDE000
2 FFF14793 0F 00000006
2 00F1E813 10 000000FF
2 7FF17893 11 000007F9
3 00100A13 14 00000001
3 014A0A33 14 00000002
3 014A0A33 14 00000004
3 003A1A93 15 00000020
3 414A8B33 16 0000001C
3 015B4B33 16 0000003C
3 FC4B0B93 17 00000000
4 00508013 00 00000000
4 00000C33 18 00000000
4 0000A183 00 00000000
4 4010D213 00 00000000
4 021082B3 00 00000000
4 00418CB3 19 00000244
4 0002ED33 1A 0000006B
5 12300D93 1B 00000123
5 80000E13 1C FFFFF800
5 41CD8EB3 1D 00000923
5 01BE5F33 1E 1FFFFF00
5 01BE2FB3 1F 00000001

// ==== compile.f ====
+incdir+design
design/coreSlice_pkg.sv
design/instrQueue.sv
design/instrDecoder.sv
design/scoreboard.sv
design/regFile.sv
design/issueStage.sv
design/aluExecute.sv
design/coreSlice.sv
verification/wbChecker.sv
verification/coreSlice_tb.sv

// ==== Bender.yml ====
package:
  name: coreSlice

sources:
  - include_dirs:
      - design
    files:
      - design/coreSlice_pkg.sv
      - design/instrQueue.sv
      - design/instrDecoder.sv
      - design/scoreboard.sv
      - design/regFile.sv
      - design/issueStage.sv
      - design/aluExecute.sv
      - design/coreSlice.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/wbChecker.sv
      - verification/coreSlice_tb.sv
